// ==== tb.f ====
design/mem_pkg.sv
design/store_lane_steer.sv
design/byte_bank.sv
design/load_lane_merge.sv
design/data_ram.sv
bench/tb_data_ram.sv

// ==== Makefile ====
# Verilator build for the data memory testbench

TOP := tb_data_ram
OBJ := obj_dir
LOG := sim.log

SRCS := $(shell cat tb.f)

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

$(OBJ)/V$(TOP): tb.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f \
		-Mdir $(OBJ) -o V$(TOP)

# the run passes only if the log holds the pass line
sim: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// ==== bench/tb_data_ram.sv ====
`timescale 1ns/1ps

// testbench for the 64 KiB data memory
// a byte-wide shadow copy follows every committed store and the
// assertions compare each load result against it on the falling edge
module tb_data_ram;

  logic              mem_clk;
  logic              rst_n_i;
  mem_pkg::mem_req_t req;
  logic [31:0]       rdata;

  // shadow bytes, plus a flag for every byte the bench has stored
  logic [7:0] shadow  [65536];
  bit         written [65536];

  int err_cnt;
  int check_cnt;
  int timeout_cnt;
  // falling edges seen so far, the checker samples on each of them
  int neg_cnt;

  data_ram dut0 (
    .mem_clk (mem_clk),
    .rst_n_i (rst_n_i),
    .req_i   (req),
    .rdata_o (rdata)
  );

  always #20 mem_clk = ~mem_clk;

  // bytes a store writes, none writes nothing
  function automatic int store_len(input mem_pkg::mem_size_t size);
    case (size)
      mem_pkg::SIZE_BYTE: return 1;
      mem_pkg::SIZE_HALF: return 2;
      mem_pkg::SIZE_WORD: return 4;
      default:            return 0;
    endcase
  endfunction

  // bytes a load looks at, none hands back the whole word
  function automatic int load_len(input mem_pkg::mem_size_t size);
    return (size == mem_pkg::SIZE_NONE) ? 4 : store_len(size);
  endfunction

  // address of byte k of an access, wrapping at 64 KiB
  function automatic logic [15:0] byte_addr(input logic [31:0] addr, input int k);
    return addr[15:0] + 16'(k);
  endfunction

  // bytes never stored by the bench hold unknown contents, so only
  // loads that touch stored bytes alone get compared
  function automatic bit load_known(input mem_pkg::mem_req_t r);
    bit ok;
    ok = 1'b1;
    for (int k = 0; k < load_len(r.size); k++) begin
      if (!written[byte_addr(r.addr, k)]) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // little-endian gather from the shadow, then LB/LBU/LH/LHU/LW rules
  function automatic logic [31:0] expected_load(input mem_pkg::mem_req_t r);
    logic [31:0] w;
    for (int k = 0; k < 4; k++) begin
      w[8*k +: 8] = shadow[byte_addr(r.addr, k)];
    end
    case (r.size)
      mem_pkg::SIZE_BYTE: return r.load_unsigned ? {24'h0, w[7:0]} : {{24{w[7]}}, w[7:0]};
      mem_pkg::SIZE_HALF: return r.load_unsigned ? {16'h0, w[15:0]} : {{16{w[15]}}, w[15:0]};
      default:            return w;
    endcase
  endfunction

  // upper bits of a sub-word result must all copy the top data bit or be zero
  function automatic bit fill_ok(input mem_pkg::mem_req_t r, input logic [31:0] d);
    case (r.size)
      mem_pkg::SIZE_BYTE: return d[31:8] == (r.load_unsigned ? 24'h0 : {24{d[7]}});
      mem_pkg::SIZE_HALF: return d[31:16] == (r.load_unsigned ? 16'h0 : {16{d[15]}});
      default:            return 1'b1;
    endcase
  endfunction

  task automatic commit_store(input mem_pkg::mem_req_t r);
    for (int k = 0; k < store_len(r.size); k++) begin
      shadow[byte_addr(r.addr, k)]  = r.wdata[8*k +: 8];
      written[byte_addr(r.addr, k)] = 1'b1;
    end
  endtask

  // the shadow commits at the same edge as the banks and obeys the same reset gate
  always @(posedge mem_clk) begin
    if (rst_n_i) begin
      commit_store(req);
    end
  end

  always @(negedge mem_clk) begin
    neg_cnt = neg_cnt + 1;
    if (load_known(req)) begin
      check_cnt = check_cnt + 1;
    end
  end

  // inputs move on the rising edge, so the falling edge sees settled data
  a_load_value: assert property (
    @(negedge mem_clk) load_known(req) |-> rdata == expected_load(req)
  ) else begin
    err_cnt = err_cnt + 1;
    $display("ERR %0t: load at %h size %0d unsigned %0b returned %h, expected %h",
             $time, req.addr, req.size, req.load_unsigned, rdata, expected_load(req));
  end

  a_load_fill: assert property (
    @(negedge mem_clk) load_known(req) |-> fill_ok(req, rdata)
  ) else begin
    err_cnt = err_cnt + 1;
    $display("ERR %0t: size %0d unsigned %0b load at %h has wrong upper fill %h",
             $time, req.size, req.load_unsigned, req.addr, rdata);
  end

  task automatic drive(input logic [31:0] addr, input logic [31:0] wdata,
                       input mem_pkg::mem_size_t size, input logic uns);
    @(posedge mem_clk);
    req <= '{addr: addr, wdata: wdata, size: size, load_unsigned: uns};
  endtask

  // waits until the checker has sampled n more falling edges
  task automatic wait_cycles(input int n);
    int target;
    int guard;
    target = neg_cnt + n;
    guard  = 0;
    // eight spare edges are plenty for a free-running clock
    while (neg_cnt < target && guard < n + 8) begin
      @(posedge mem_clk);
      guard = guard + 1;
    end
    if (neg_cnt < target) begin
      timeout_cnt = timeout_cnt + 1;
      $display("timeout: the checker did not sample within %0d cycles", guard);
    end
  endtask

  function automatic logic [31:0] rand_aligned();
    logic [31:0] r;
    r      = $urandom;
    r[1:0] = 2'b00;
    return r;
  endfunction

  task automatic check_word_readback();
    logic [31:0] a;
    for (int i = 0; i < 16; i++) begin
      a = rand_aligned();
      drive(a, $urandom, mem_pkg::SIZE_WORD, 1'b0);
      drive(a, $urandom, mem_pkg::SIZE_NONE, 1'b0);
    end
  endtask

  // bytes and halves land inside a known word, which is then read whole
  task automatic check_sub_word_stores();
    logic [31:0] a;
    for (int i = 0; i < 12; i++) begin
      a = rand_aligned();
      drive(a, $urandom, mem_pkg::SIZE_WORD, 1'b0);
      drive(a + 32'(i % 4), $urandom, mem_pkg::SIZE_BYTE, 1'b0);
      drive(a, $urandom, mem_pkg::SIZE_NONE, 1'b0);
      drive(a + 32'(i % 3), $urandom, mem_pkg::SIZE_HALF, 1'b0);
      drive(a, $urandom, mem_pkg::SIZE_NONE, 1'b1);
    end
  endtask

  // low bits 1 to 3, so every word and the half at 3 spill into row+1
  task automatic check_unaligned();
    logic [31:0] a;
    logic [31:0] w;
    for (int i = 0; i < 12; i++) begin
      a      = $urandom;
      a[1:0] = 2'(1 + (i % 3));
      w      = $urandom;
      drive(a, w, mem_pkg::SIZE_WORD, 1'b0);
      drive(a, 32'h0, mem_pkg::SIZE_NONE, 1'b0);
      drive({a[31:2], 2'b00}, 32'h0, mem_pkg::SIZE_NONE, 1'b0);
      drive({a[31:2], 2'b00} + 32'd4, 32'h0, mem_pkg::SIZE_NONE, 1'b0);
      // rewriting the same half keeps the contents while it loads
      drive(a + 32'd1, w >> 8, mem_pkg::SIZE_HALF, i[0]);
      drive(a, 32'h0, mem_pkg::SIZE_NONE, 1'b1);
    end
    // a half at low bits 3 takes bank 3 of one row and bank 0 of the next
    a = rand_aligned() | 32'd3;
    drive(a, 32'h0000_81c3, mem_pkg::SIZE_HALF, 1'b0);
    drive(a, 32'h0000_81c3, mem_pkg::SIZE_HALF, 1'b0);
    drive(a, 32'h0000_81c3, mem_pkg::SIZE_HALF, 1'b1);
    drive(a - 32'd3, 32'h0, mem_pkg::SIZE_NONE, 1'b0);
  endtask

  // byte tops 0,1,1,0 and half tops at offsets 0..2 of 1,1,0
  task automatic check_extension();
    logic [31:0] a;
    logic [31:0] pat;
    a   = rand_aligned();
    pat = 32'h7f80_ff01;
    drive(a, pat, mem_pkg::SIZE_WORD, 1'b0);
    for (int u = 0; u < 2; u++) begin
      for (int k = 0; k < 4; k++) begin
        drive(a + 32'(k), pat >> (8 * k), mem_pkg::SIZE_BYTE, u[0]);
      end
      for (int k = 0; k < 3; k++) begin
        drive(a + 32'(k), pat >> (8 * k), mem_pkg::SIZE_HALF, u[0]);
      end
    end
  endtask

  task automatic check_no_write();
    logic [31:0] a;
    logic [31:0] pat;
    a   = rand_aligned();
    pat = $urandom;
    drive(a, pat, mem_pkg::SIZE_WORD, 1'b0);
    // none carries data on the bus but never stores it
    drive(a, ~pat, mem_pkg::SIZE_NONE, 1'b0);
    drive(a + 32'd1, ~pat, mem_pkg::SIZE_NONE, 1'b1);
    // stores while reset is low are dropped and loads still work
    drive(a, ~pat, mem_pkg::SIZE_WORD, 1'b0);
    rst_n_i <= 1'b0;
    drive(a + 32'd2, ~pat, mem_pkg::SIZE_HALF, 1'b0);
    drive(a + 32'd3, ~pat, mem_pkg::SIZE_BYTE, 1'b0);
    drive(a, 32'h0, mem_pkg::SIZE_NONE, 1'b0);
    rst_n_i <= 1'b1;
    drive(a, 32'h0, mem_pkg::SIZE_NONE, 1'b0);
  endtask

  // bits 31..16 are ignored, so a high address is an alias of its low half
  task automatic check_alias();
    logic [31:0] lo;
    logic [31:0] hi;
    for (int i = 0; i < 8; i++) begin
      lo         = rand_aligned();
      lo[31:16]  = 16'h0;
      hi         = lo;
      hi[31:16]  = 16'($urandom_range(65535, 1));
      drive(hi, $urandom, mem_pkg::SIZE_WORD, 1'b0);
      drive(lo, 32'h0, mem_pkg::SIZE_NONE, 1'b0);
      drive(lo + 32'd1, $urandom, mem_pkg::SIZE_BYTE, 1'b0);
      drive(hi, 32'h0, mem_pkg::SIZE_NONE, 1'b0);
    end
    // a word at the very top wraps its last two bytes to address zero
    drive(32'hffff_fffe, $urandom, mem_pkg::SIZE_WORD, 1'b0);
    drive(32'h0000_fffe, 32'h0, mem_pkg::SIZE_NONE, 1'b0);
    drive(32'h0001_0000, 32'h0, mem_pkg::SIZE_HALF, 1'b1);
  endtask

  // a small window keeps the mix hitting bytes it stored before
  task automatic random_mix();
    logic [31:0] a;
    for (int i = 0; i < 200; i++) begin
      a = {16'($urandom), 16'h0100 + 16'($urandom_range(63, 0))};
      drive(a, $urandom, mem_pkg::mem_size_t'($urandom_range(3, 0)), 1'($urandom));
    end
  endtask

  initial begin
    void'($urandom(65180));
    mem_clk     = 1'b0;
    rst_n_i     = 1'b0;
    req         = '{addr: '0, wdata: '0, size: mem_pkg::SIZE_NONE, load_unsigned: 1'b0};
    err_cnt     = 0;
    check_cnt   = 0;
    timeout_cnt = 0;
    neg_cnt     = 0;
    wait_cycles(4);
    rst_n_i <= 1'b1;
    check_word_readback();
    check_sub_word_stores();
    check_unaligned();
    check_extension();
    check_no_write();
    check_alias();
    random_mix();
    drive(32'h0, 32'h0, mem_pkg::SIZE_NONE, 1'b0);
    // let the checker sample the last requests
    wait_cycles(2);
    $display("checks %0d errors %0d timeouts %0d", check_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0 && check_cnt > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== design/data_ram.sv ====
`timescale 1ns/1ps

// byte-addressed 64 KiB data memory of the core
// stores commit on the edge and loads are combinational
module data_ram (
  input  logic              mem_clk,
  input  logic              rst_n_i,
  input  mem_pkg::mem_req_t req_i,
  output logic [31:0]       rdata_o
);

  // write lane, read row and read byte per bank
  mem_pkg::bank_wr_t         lanes      [mem_pkg::NUM_BANKS];
  logic [mem_pkg::ROW_W-1:0] rd_rows    [mem_pkg::NUM_BANKS];
  logic [7:0]                bank_bytes [mem_pkg::NUM_BANKS];

  store_lane_steer u_steer (
    .rst_n_i (rst_n_i),
    .req_i   (req_i),
    .lanes_o (lanes)
  );

  // the bytes of one access always sit in different banks, which is
  // what makes unaligned halves and words single-cycle
  for (genvar b = 0; b < mem_pkg::NUM_BANKS; b++) begin : g_bank
    byte_bank u_bank (
      .mem_clk   (mem_clk),
      .wr_i      (lanes[b]),
      .rd_row_i  (rd_rows[b]),
      .rd_byte_o (bank_bytes[b])
    );
  end

  load_lane_merge u_merge (
    .req_i        (req_i),
    .rd_rows_o    (rd_rows),
    .bank_bytes_i (bank_bytes),
    .rdata_o      (rdata_o)
  );

  // a word written at one edge reads back through both lane blocks
  // in the next cycle when the address is held
  a_word_readback: assert property (
    @(posedge mem_clk) rst_n_i && req_i.size == mem_pkg::SIZE_WORD |=>
      req_i.addr != $past(req_i.addr) ||
      req_i.size inside {mem_pkg::SIZE_BYTE, mem_pkg::SIZE_HALF} ||
      rdata_o == $past(req_i.wdata)
  ) else $error("word store did not read back at %h", $past(req_i.addr));

endmodule

// ==== design/load_lane_merge.sv ====
`timescale 1ns/1ps

// picks the rows to read from every bank and turns the four bank bytes
// into the load result the core expects
module load_lane_merge (
  input  mem_pkg::mem_req_t         req_i,
  output logic [mem_pkg::ROW_W-1:0] rd_rows_o [mem_pkg::NUM_BANKS],
  input  logic [7:0]                bank_bytes_i [mem_pkg::NUM_BANKS],
  output logic [31:0]               rdata_o
);

  // bank bytes side by side in bank order
  logic [31:0] bank_word;
  // doubled word shifted down so a plain slice gives the rotation
  logic [63:0] word_pair;
  // bytes in address order, byte 0 is the byte at addr
  logic [31:0] rot_word;
  // fill bit for byte and half results
  logic        ext_byte;
  logic        ext_half;

  // the same row rule as the store path keeps loads and stores aligned
  for (genvar b = 0; b < mem_pkg::NUM_BANKS; b++) begin : g_row
    assign rd_rows_o[b] = mem_pkg::bank_row(req_i.addr, mem_pkg::lane_t'(b));
  end

  always_comb begin
    for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
      bank_word[8*b +: 8] = bank_bytes_i[b];
    end
  end

  // result byte k comes from bank (addr[1:0] + k) mod 4
  assign word_pair = {bank_word, bank_word} >> {req_i.addr[mem_pkg::LANE_W-1:0], 3'b000};
  assign rot_word  = word_pair[31:0];

  // LBU and LHU fill with zeros, LB and LH copy the top bit
  assign ext_byte = !req_i.load_unsigned && rot_word[7];
  assign ext_half = !req_i.load_unsigned && rot_word[15];

  always_comb begin
    case (req_i.size)
      mem_pkg::SIZE_BYTE: rdata_o = {{24{ext_byte}}, rot_word[7:0]};
      mem_pkg::SIZE_HALF: rdata_o = {{16{ext_half}}, rot_word[15:0]};
      // word and none both return all four bytes
      default:            rdata_o = rot_word;
    endcase
  end

  // an LBU result is the byte of the bank that addr selects, with nothing above it
  always_comb begin
    if (req_i.size == mem_pkg::SIZE_BYTE && req_i.load_unsigned) begin
      a_lbu_zero: assert (rdata_o == {24'h0, bank_bytes_i[req_i.addr[mem_pkg::LANE_W-1:0]]})
        else $error("unsigned byte load returned %h", rdata_o);
    end
  end

endmodule

// ==== design/byte_bank.sv ====
`timescale 1ns/1ps

// one byte-wide slice of the data memory
// writes land on the clock edge while reads are asynchronous
module byte_bank (
  input  logic                      mem_clk,
  input  mem_pkg::bank_wr_t         wr_i,
  input  logic [mem_pkg::ROW_W-1:0] rd_row_i,
  output logic [7:0]                rd_byte_o
);

  // storage holds whatever the core left in it, reset never touches it
  logic [7:0] mem_q [mem_pkg::BANK_ROWS];

  // one byte per edge at most, the steer block decides which
  always_ff @(posedge mem_clk) begin
    if (wr_i.we) begin
      mem_q[wr_i.row] <= wr_i.wbyte;
    end
  end

  // a load in the same cycle as a store still sees the old byte
  assign rd_byte_o = mem_q[rd_row_i];

  // an enabled write with unknown row or data would corrupt an unknown location
  a_wr_known: assert property (
    @(posedge mem_clk) wr_i.we |-> !$isunknown({wr_i.row, wr_i.wbyte})
  ) else $error("bank write with unknown row or data");

endmodule

// ==== design/store_lane_steer.sv ====
`timescale 1ns/1ps

// splits one store request into a write lane per byte bank
module store_lane_steer (
  input  logic              rst_n_i,
  input  mem_pkg::mem_req_t req_i,
  output mem_pkg::bank_wr_t lanes_o [mem_pkg::NUM_BANKS]
);

  // number of bytes the store covers, zero for none
  logic [2:0] byte_cnt;

  always_comb begin
    case (req_i.size)
      mem_pkg::SIZE_BYTE: byte_cnt = 3'd1;
      mem_pkg::SIZE_HALF: byte_cnt = 3'd2;
      mem_pkg::SIZE_WORD: byte_cnt = 3'd4;
      default:            byte_cnt = 3'd0;
    endcase
  end

  for (genvar b = 0; b < mem_pkg::NUM_BANKS; b++) begin : g_lane
    // request byte k that maps onto this bank
    mem_pkg::lane_t k;

    assign k = mem_pkg::lane_offset(req_i.addr, mem_pkg::lane_t'(b));

    // the bank takes part only if its offset is inside the access
    // and writes stay blocked for as long as reset is held
    assign lanes_o[b] = '{
      we:    rst_n_i && ({1'b0, k} < byte_cnt),
      row:   mem_pkg::bank_row(req_i.addr, mem_pkg::lane_t'(b)),
      wbyte: req_i.wdata[{k, 3'b000} +: 8]
    };
  end

  // every offset appears exactly once over the four banks, so the
  // number of enabled lanes has to match the access size
  always_comb begin
    logic [2:0] we_cnt;
    logic [2:0] exp_cnt;
    we_cnt = '0;
    for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
      we_cnt = we_cnt + {2'b00, lanes_o[b].we};
    end
    // the size code is the log2 of the byte count, none and reset enable nothing
    if (!rst_n_i || req_i.size == mem_pkg::SIZE_NONE) begin
      exp_cnt = 3'd0;
    end else begin
      exp_cnt = 3'd1 << req_i.size;
    end
    a_lane_cnt: assert (we_cnt == exp_cnt)
      else $error("store lanes enabled %0d, expected %0d", we_cnt, exp_cnt);
  end

endmodule

// ==== design/mem_pkg.sv ====
// shared geometry, request encoding and lane types for the data memory
package mem_pkg;

  // four byte banks make up one 32-bit row
  localparam int NUM_BANKS = 4;
  // 16384 rows of four bytes give the 64 KiB capacity
  localparam int BANK_ROWS = 16384;
  // row index width, so the row wraps at 64 KiB by itself
  localparam int ROW_W     = 14;
  // the core always presents a full 32-bit byte address
  localparam int ADDR_W    = 32;
  // address bits that pick a bank inside a row
  localparam int LANE_W    = 2;

  // bank number inside a row
  typedef logic [LANE_W-1:0] lane_t;

  // access size as the core encodes it on the bus
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2,
    SIZE_NONE = 2'd3
  } mem_size_t;

  // one request per cycle, a level and not a handshake
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [31:0]       wdata;
    mem_size_t         size;
    logic              load_unsigned;
  } mem_req_t;

  // write lane into a single byte bank
  typedef struct packed {
    logic             we;
    logic [ROW_W-1:0] row;
    logic [7:0]       wbyte;
  } bank_wr_t;

  // offset k of the request byte that lands in this bank
  function automatic lane_t lane_offset(input logic [ADDR_W-1:0] addr, input lane_t lane);
    return lane - addr[LANE_W-1:0];
  endfunction

  // row of this bank touched by the access at addr
  // banks below the start lane hold bytes that spilled into the next row
  function automatic logic [ROW_W-1:0] bank_row(input logic [ADDR_W-1:0] addr,
                                                input lane_t lane);
    logic wrap;
    wrap = lane < addr[LANE_W-1:0];
    return addr[ROW_W+LANE_W-1:LANE_W] + {{(ROW_W-1){1'b0}}, wrap};
  endfunction

endpackage
